/* geometry_front_end.f */
source/fixed_pkg.sv
source/types_pkg.sv
source/fixed_reciprocal_divider.sv
source/projection.sv
source/backface_cull.sv
source/geometry_front_end.sv
tests/tb_geometry_front_end.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f geometry_front_end.f \
    --top-module tb_geometry_front_end \
    -o sim_geometry_front_end

output=$(./obj_dir/sim_geometry_front_end 2>&1) || true
echo "$output"

# Exits non-zero when the pass line is missing
echo "$output" | grep -qx "sim passed"

/* source/backface_cull.sv */
`timescale 1ns/10ps

module backface_cull (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      projected_valid,
    output logic                      projected_ready,
    input  types_pkg::triangle_t      projected_data,
    input  types_pkg::triangle_meta_t projected_meta,
    output logic                      triangle_m_valid,
    input  logic                      triangle_m_ready,
    output types_pkg::triangle_t      triangle_m_data,
    output types_pkg::triangle_meta_t triangle_m_metadata,
    output logic [15:0]               culled_count
);
    import types_pkg::*;

    position_t          p0;
    position_t          p1;
    position_t          p2;
    logic signed [63:0] e1x;
    logic signed [63:0] e1y;
    logic signed [63:0] e2x;
    logic signed [63:0] e2y;
    logic signed [63:0] area;
    logic               front_facing;
    logic               in_xfer;

    assign p0 = projected_data.v0.position;
    assign p1 = projected_data.v1.position;
    assign p2 = projected_data.v2.position;

    // Edge vectors from v0, widened before the products
    assign e1x = 64'($signed(p1.x)) - 64'($signed(p0.x));
    assign e1y = 64'($signed(p1.y)) - 64'($signed(p0.y));
    assign e2x = 64'($signed(p2.x)) - 64'($signed(p0.x));
    assign e2y = 64'($signed(p2.y)) - 64'($signed(p0.y));

    // Twice the signed area, positive for counter-clockwise winding
    assign area         = e1x * e2y - e2x * e1y;
    assign front_facing = area > 0;

    assign projected_ready = !triangle_m_valid || triangle_m_ready;
    assign in_xfer         = projected_valid && projected_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            triangle_m_valid <= 1'b0;
            culled_count     <= '0;
        end else begin
            if (projected_ready) begin
                triangle_m_valid <= projected_valid && front_facing;
            end
            // Wraps at 16 bits
            if (in_xfer && !front_facing) begin
                culled_count <= culled_count + 16'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_xfer && front_facing) begin
            triangle_m_data     <= projected_data;
            triangle_m_metadata <= projected_meta;
        end
    end

    a_output_stable: assert property (
        @(posedge clk) disable iff (!rstn)
        triangle_m_valid && !triangle_m_ready |=>
            triangle_m_valid && $stable(triangle_m_data) && $stable(triangle_m_metadata)
    ) else $error("output triangle changed while stalled");

endmodule

/* source/fixed_pkg.sv */
package fixed_pkg;

    // Number of fraction bits in the Q16.16 format
    localparam int FRAC_BITS = 16;

    // Signed Q16.16, 16 integer bits and 16 fraction bits
    typedef logic signed [31:0] fixed;

    // Full-width product, scaled back down by the fraction bits
    function automatic fixed mul(fixed a, fixed b);
        logic signed [63:0] product;
        product = a * b;
        return fixed'(product >>> FRAC_BITS);
    endfunction

    // Limit a value to the range low..high
    function automatic fixed clamp(fixed value, fixed low, fixed high);
        fixed result;
        result = value;
        if (value < low) begin
            result = low;
        end else if (value > high) begin
            result = high;
        end
        return result;
    endfunction

    // Real to fixed, truncated toward zero
    function automatic fixed rtof(real value);
        return fixed'($rtoi(value * (2.0 ** FRAC_BITS)));
    endfunction

    // Depth range kept by the projection stage
    localparam fixed NEAR_PLANE = rtof(1.0);
    localparam fixed FAR_PLANE  = rtof(1000.0);

endpackage

/* source/fixed_reciprocal_divider.sv */
`timescale 1ns/10ps

module fixed_reciprocal_divider (
    input  logic            clk,
    input  logic            rstn,
    input  logic            divisor_s_valid,
    output logic            divisor_s_ready,
    input  fixed_pkg::fixed divisor_s_data,
    output logic            result_m_valid,
    input  logic            result_m_ready,
    output fixed_pkg::fixed result_m_data
);
    import fixed_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOAD,
        S_RUN,
        S_DONE
    } state_t;

    state_t      state;
    logic [4:0]  iter;
    fixed        divisor_q;
    logic [32:0] rem;
    logic [32:0] rem_shift;
    logic [31:0] quot;
    logic        sub_ok;

    // Dividend is 2^32, so every bit shifted in below the top one is zero
    assign rem_shift = {rem[31:0], 1'b0};
    assign sub_ok    = rem_shift >= {1'b0, divisor_q};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= S_IDLE;
            iter  <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (divisor_s_valid) begin
                        state <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    iter  <= '0;
                    state <= S_RUN;
                end
                S_RUN: begin
                    iter <= iter + 5'd1;
                    if (iter == 5'd31) begin
                        state <= S_DONE;
                    end
                end
                S_DONE: begin
                    if (result_m_ready) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Restoring shift-subtract, one quotient bit per cycle
    always_ff @(posedge clk) begin
        case (state)
            S_IDLE: begin
                if (divisor_s_valid) begin
                    divisor_q <= divisor_s_data;
                end
            end
            S_LOAD: begin
                // Bit 32 of the dividend seeds the remainder
                rem  <= 33'd1;
                quot <= '0;
            end
            S_RUN: begin
                rem  <= sub_ok ? rem_shift - {1'b0, divisor_q} : rem_shift;
                quot <= {quot[30:0], sub_ok};
            end
            default: begin
            end
        endcase
    end

    assign divisor_s_ready = (state == S_IDLE);
    assign result_m_valid  = (state == S_DONE);
    assign result_m_data   = fixed'(quot);

    // A zero or negative divisor gives a meaningless quotient
    a_divisor_positive: assert property (
        @(posedge clk) disable iff (!rstn)
        divisor_s_valid && divisor_s_ready |-> divisor_s_data > 0
    ) else $error("divider accepted a non-positive divisor");

    a_result_stable: assert property (
        @(posedge clk) disable iff (!rstn)
        result_m_valid && !result_m_ready |=> result_m_valid && $stable(result_m_data)
    ) else $error("divider result changed while stalled");

endmodule

/* source/geometry_front_end.sv */
`timescale 1ns/10ps

module geometry_front_end #(
    parameter real FOCAL_LENGTH = 0.1,
    parameter real ASPECT_RATIO = 1.0
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      triangle_s_valid,
    output logic                      triangle_s_ready,
    input  types_pkg::triangle_t      triangle_s_data,
    input  types_pkg::triangle_meta_t triangle_s_metadata,
    output logic                      triangle_m_valid,
    input  logic                      triangle_m_ready,
    output types_pkg::triangle_t      triangle_m_data,
    output types_pkg::triangle_meta_t triangle_m_metadata,
    output logic [15:0]               culled_count
);
    import types_pkg::*;

    // Projected stream between the two stages
    logic           projected_valid;
    logic           projected_ready;
    triangle_t      projected_data;
    triangle_meta_t projected_meta;

    projection #(
        .FOCAL_LENGTH (FOCAL_LENGTH),
        .ASPECT_RATIO (ASPECT_RATIO)
    ) i_projection (
        .clk                 (clk),
        .rstn                (rstn),
        .triangle_s_valid    (triangle_s_valid),
        .triangle_s_ready    (triangle_s_ready),
        .triangle_s_data     (triangle_s_data),
        .triangle_s_metadata (triangle_s_metadata),
        .projected_valid     (projected_valid),
        .projected_ready     (projected_ready),
        .projected_data      (projected_data),
        .projected_meta      (projected_meta)
    );

    backface_cull i_backface_cull (
        .clk                 (clk),
        .rstn                (rstn),
        .projected_valid     (projected_valid),
        .projected_ready     (projected_ready),
        .projected_data      (projected_data),
        .projected_meta      (projected_meta),
        .triangle_m_valid    (triangle_m_valid),
        .triangle_m_ready    (triangle_m_ready),
        .triangle_m_data     (triangle_m_data),
        .triangle_m_metadata (triangle_m_metadata),
        .culled_count        (culled_count)
    );

endmodule

/* source/projection.sv */
`timescale 1ns/10ps

module projection #(
    parameter real FOCAL_LENGTH = 0.1,
    parameter real ASPECT_RATIO = 1.0
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      triangle_s_valid,
    output logic                      triangle_s_ready,
    input  types_pkg::triangle_t      triangle_s_data,
    input  types_pkg::triangle_meta_t triangle_s_metadata,
    output logic                      projected_valid,
    input  logic                      projected_ready,
    output types_pkg::triangle_t      projected_data,
    output types_pkg::triangle_meta_t projected_meta
);
    import fixed_pkg::*;
    import types_pkg::*;

    // Focal lengths in fixed point, x corrected for aspect ratio
    localparam fixed FX = rtof(FOCAL_LENGTH / ASPECT_RATIO);
    localparam fixed FY = rtof(FOCAL_LENGTH);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD,
        S_WAIT,
        S_PROJ,
        S_OUT
    } state_t;

    state_t         state;
    logic [1:0]     vtx;
    triangle_t      triangle_in;
    triangle_meta_t meta_in;
    fixed           rec_z [3];
    fixed           current_z;

    logic divisor_s_valid;
    logic divisor_s_ready;
    fixed divisor_s_data;
    logic result_m_valid;
    logic result_m_ready;
    fixed result_m_data;

    // x' = fx * x / z, y' = fy * y / z, z' = 1 / z
    function automatic vertex_t project_vertex(vertex_t v, fixed rz);
        vertex_t p;
        p.position.x = mul(FX, mul(v.position.x, rz));
        p.position.y = mul(FY, mul(v.position.y, rz));
        p.position.z = rz;
        p.color      = v.color;
        return p;
    endfunction

    fixed_reciprocal_divider i_divider (
        .clk             (clk),
        .rstn            (rstn),
        .divisor_s_valid (divisor_s_valid),
        .divisor_s_ready (divisor_s_ready),
        .divisor_s_data  (divisor_s_data),
        .result_m_valid  (result_m_valid),
        .result_m_ready  (result_m_ready),
        .result_m_data   (result_m_data)
    );

    // Depth of the vertex currently being sent to the divider
    always_comb begin
        case (vtx)
            2'd0:    current_z = triangle_in.v0.position.z;
            2'd1:    current_z = triangle_in.v1.position.z;
            default: current_z = triangle_in.v2.position.z;
        endcase
    end

    assign divisor_s_data = clamp(current_z, NEAR_PLANE, FAR_PLANE);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= S_IDLE;
            vtx   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (triangle_s_valid) begin
                        vtx   <= '0;
                        state <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    if (divisor_s_ready) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (result_m_valid) begin
                        if (vtx == 2'd2) begin
                            state <= S_PROJ;
                        end else begin
                            vtx   <= vtx + 2'd1;
                            state <= S_LOAD;
                        end
                    end
                end
                S_PROJ: begin
                    state <= S_OUT;
                end
                S_OUT: begin
                    if (projected_ready) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && triangle_s_valid) begin
            triangle_in <= triangle_s_data;
            meta_in     <= triangle_s_metadata;
        end
        if (state == S_WAIT && result_m_valid) begin
            rec_z[vtx] <= result_m_data;
        end
        // All three vertices in the same cycle
        if (state == S_PROJ) begin
            projected_data.v0 <= project_vertex(triangle_in.v0, rec_z[0]);
            projected_data.v1 <= project_vertex(triangle_in.v1, rec_z[1]);
            projected_data.v2 <= project_vertex(triangle_in.v2, rec_z[2]);
        end
    end

    assign triangle_s_ready = (state == S_IDLE);
    assign divisor_s_valid  = (state == S_LOAD);
    assign result_m_ready   = (state == S_WAIT);
    assign projected_valid  = (state == S_OUT);
    assign projected_meta   = meta_in;

    a_projected_held: assert property (
        @(posedge clk) disable iff (!rstn)
        projected_valid && !projected_ready |=> projected_valid
    ) else $error("projected_valid dropped before the transfer");

endmodule

/* source/types_pkg.sv */
package types_pkg;

    // Vertex position in view space
    typedef struct packed {
        fixed_pkg::fixed x;
        fixed_pkg::fixed y;
        fixed_pkg::fixed z;
    } position_t;

    // Position plus 24-bit RGB colour
    typedef struct packed {
        position_t   position;
        logic [23:0] color;
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    // Travels alongside each triangle untouched
    typedef struct packed {
        logic [15:0] triangle_id;
        logic [15:0] object_id;
    } triangle_meta_t;

endpackage

/* tests/tb_geometry_front_end.sv */
`timescale 1ns/10ps

module tb_geometry_front_end;
    import fixed_pkg::*;
    import types_pkg::*;

    localparam int RANDOM_TRIANGLES = 40;
    localparam int NUM_TRIANGLES    = RANDOM_TRIANGLES + 3;
    localparam int TIMEOUT_CYCLES   = NUM_TRIANGLES * 150 + 1000;

    // Default focal length 0.1 and aspect ratio 1.0 give equal fx and fy
    localparam fixed MODEL_FX = fixed'($rtoi(0.1 * 65536.0));
    localparam fixed MODEL_FY = fixed'($rtoi(0.1 * 65536.0));

    logic           clk = 1'b0;
    logic           rstn;
    logic           triangle_s_valid;
    logic           triangle_s_ready;
    triangle_t      triangle_s_data;
    triangle_meta_t triangle_s_metadata;
    logic           triangle_m_valid;
    logic           triangle_m_ready;
    triangle_t      triangle_m_data;
    triangle_meta_t triangle_m_metadata;
    logic [15:0]    culled_count;
    logic [15:0]    expected_culled = '0;
    int             cycle_count = 0;
    logic [31:0]    rng_state = 32'h69973fef;

    geometry_front_end i_geometry_front_end (
        .clk                 (clk),
        .rstn                (rstn),
        .triangle_s_valid    (triangle_s_valid),
        .triangle_s_ready    (triangle_s_ready),
        .triangle_s_data     (triangle_s_data),
        .triangle_s_metadata (triangle_s_metadata),
        .triangle_m_valid    (triangle_m_valid),
        .triangle_m_ready    (triangle_m_ready),
        .triangle_m_data     (triangle_m_data),
        .triangle_m_metadata (triangle_m_metadata),
        .culled_count        (culled_count)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Q16.16 product taken from bits 47..16 of the full signed product
    function automatic fixed fixed_product(fixed a, fixed b);
        logic signed [63:0] p;
        p = 64'(a) * 64'(b);
        return p[47:16];
    endfunction

    // Depth limited to 1.0..1000.0 before floor(2^32 / z)
    function automatic fixed depth_reciprocal(fixed z);
        logic [63:0] zc;
        logic [63:0] q;
        if (z < NEAR_PLANE) begin
            zc = 64'(NEAR_PLANE);
        end else if (z > FAR_PLANE) begin
            zc = 64'(FAR_PLANE);
        end else begin
            zc = 64'(z);
        end
        q = (64'd1 << 32) / zc;
        return q[31:0];
    endfunction

    function automatic vertex_t model_vertex(vertex_t v);
        vertex_t p;
        fixed    rz;
        rz = depth_reciprocal(v.position.z);
        p.position.x = fixed_product(MODEL_FX, fixed_product(v.position.x, rz));
        p.position.y = fixed_product(MODEL_FY, fixed_product(v.position.y, rz));
        p.position.z = rz;
        p.color      = v.color;
        return p;
    endfunction

    function automatic triangle_t model_triangle(triangle_t t);
        triangle_t p;
        p.v0 = model_vertex(t.v0);
        p.v1 = model_vertex(t.v1);
        p.v2 = model_vertex(t.v2);
        return p;
    endfunction

    // Counter-clockwise winding gives a positive doubled area
    function automatic bit model_front(triangle_t p);
        logic signed [63:0] x0;
        logic signed [63:0] y0;
        logic signed [63:0] x1;
        logic signed [63:0] y1;
        logic signed [63:0] x2;
        logic signed [63:0] y2;
        x0 = p.v0.position.x;
        y0 = p.v0.position.y;
        x1 = p.v1.position.x;
        y1 = p.v1.position.y;
        x2 = p.v2.position.x;
        y2 = p.v2.position.y;
        return ((x1 - x0) * (y2 - y0) - (x2 - x0) * (y1 - y0)) > 0;
    endfunction

    function automatic vertex_t make_vertex(real x, real y, real z, logic [23:0] color);
        vertex_t v;
        v.position.x = fixed'($rtoi(x * 65536.0));
        v.position.y = fixed'($rtoi(y * 65536.0));
        v.position.z = fixed'($rtoi(z * 65536.0));
        v.color      = color;
        return v;
    endfunction

    // x and y within +-64.0 and depth 0.5 to 16.5 so some get clamped
    function automatic vertex_t random_vertex();
        vertex_t     v;
        logic [31:0] r;
        r = next_random();
        v.position.x = fixed'($signed(r) >>> 9);
        r = next_random();
        v.position.y = fixed'($signed(r) >>> 9);
        r = next_random();
        v.position.z = fixed'({12'd0, r[31:12]} + 32'h8000);
        r = next_random();
        v.color = r[31:8];
        return v;
    endfunction

    function automatic triangle_t reference_triangle();
        triangle_t t;
        t.v0 = make_vertex(-1.0, -1.0, 2.0, 24'hff0000);
        t.v1 = make_vertex(1.0, -1.0, 2.0, 24'h00ff00);
        t.v2 = make_vertex(0.0, 1.0, 4.0, 24'h0000ff);
        return t;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic compare_triangle(input triangle_t got, input triangle_t exp);
        vertex_t gv [3];
        vertex_t ev [3];
        gv = '{got.v0, got.v1, got.v2};
        ev = '{exp.v0, exp.v1, exp.v2};
        for (int i = 0; i < 3; i++) begin
            check_word($sformatf("triangle_m_data.v%0d.x", i), gv[i].position.x,
                       ev[i].position.x);
            check_word($sformatf("triangle_m_data.v%0d.y", i), gv[i].position.y,
                       ev[i].position.y);
            check_word($sformatf("triangle_m_data.v%0d.z", i), gv[i].position.z,
                       ev[i].position.z);
            check_word($sformatf("triangle_m_data.v%0d.color", i), {8'd0, gv[i].color},
                       {8'd0, ev[i].color});
        end
    endtask

    task automatic compare_meta(input triangle_meta_t got, input triangle_meta_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL triangle_m_metadata got %h expected %h", got, exp));
        end
    endtask

    task automatic compare_count(input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL culled_count got %h expected %h", got, exp));
        end
    endtask

    // Called 1 ns after a rising edge and returns at the same phase
    task automatic drive_triangle(input triangle_t t, input triangle_meta_t m);
        logic accepted;
        triangle_s_valid    = 1'b1;
        triangle_s_data     = t;
        triangle_s_metadata = m;
        do begin
            @(negedge clk);
            accepted = triangle_s_ready;
            @(posedge clk);
            #1;
        end while (!accepted);
        triangle_s_valid = 1'b0;
    endtask

    task automatic take_output(output triangle_t d, output triangle_meta_t m);
        triangle_m_ready = 1'b1;
        do begin
            @(negedge clk);
        end while (!triangle_m_valid);
        d = triangle_m_data;
        m = triangle_m_metadata;
        @(posedge clk);
        #1;
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        compare_flag("triangle_m_valid", triangle_m_valid, 1'b0);
        compare_flag("triangle_s_ready", triangle_s_ready, 1'b1);
        compare_count(culled_count, 16'd0);
        @(posedge clk);
        #1;
    endtask

    task automatic test_front_facing();
        triangle_t      t;
        triangle_t      got_d;
        triangle_meta_t m;
        triangle_meta_t got_m;
        t = reference_triangle();
        m = '{triangle_id: 16'h0001, object_id: 16'h00a5};
        drive_triangle(t, m);
        take_output(got_d, got_m);
        compare_triangle(got_d, model_triangle(t));
        compare_meta(got_m, m);
    endtask

    task automatic test_back_facing();
        triangle_t      t;
        triangle_t      s;
        triangle_meta_t m;
        t = reference_triangle();
        // Swapping two vertices reverses the winding
        s.v0 = t.v0;
        s.v1 = t.v2;
        s.v2 = t.v1;
        m = '{triangle_id: 16'h0002, object_id: 16'h00a5};
        drive_triangle(s, m);
        do begin
            @(negedge clk);
            if (triangle_m_valid) begin
                abort_run("Back-facing triangle reached the output");
            end
        end while (culled_count === expected_culled);
        expected_culled = expected_culled + 16'd1;
        compare_count(culled_count, expected_culled);
        @(posedge clk);
        #1;
    endtask

    task automatic test_depth_clamp();
        triangle_t      t;
        triangle_t      got_d;
        triangle_meta_t m;
        triangle_meta_t got_m;
        t.v0 = make_vertex(0.0, 0.0, 0.25, 24'h102030);
        t.v1 = make_vertex(100.0, 0.0, 5000.0, 24'h405060);
        t.v2 = make_vertex(0.0, 4.0, 2.0, 24'h708090);
        m = '{triangle_id: 16'h0003, object_id: 16'h0c1a};
        drive_triangle(t, m);
        take_output(got_d, got_m);
        // 1/1.0 and floor(2^32 / (1000 * 2^16))
        check_word("triangle_m_data.v0.z", got_d.v0.position.z, 32'h0001_0000);
        check_word("triangle_m_data.v1.z", got_d.v1.position.z, 32'd65);
        compare_triangle(got_d, model_triangle(t));
        compare_meta(got_m, m);
    endtask

    task automatic test_random_stream();
        triangle_t      tris [RANDOM_TRIANGLES];
        triangle_meta_t metas [RANDOM_TRIANGLES];
        triangle_t      exp_data [$];
        triangle_meta_t exp_meta [$];
        triangle_t      expected;
        logic [31:0]    r;
        for (int i = 0; i < RANDOM_TRIANGLES; i++) begin
            tris[i] = '{random_vertex(), random_vertex(), random_vertex()};
            r = next_random();
            metas[i] = '{triangle_id: 16'(i + 256), object_id: r[31:16]};
            expected = model_triangle(tris[i]);
            if (model_front(expected)) begin
                exp_data.push_back(expected);
                exp_meta.push_back(metas[i]);
            end else begin
                expected_culled = expected_culled + 16'd1;
            end
        end
        fork
            begin
                for (int i = 0; i < RANDOM_TRIANGLES; i++) begin
                    drive_triangle(tris[i], metas[i]);
                end
            end
            begin
                while (exp_data.size() > 0) begin
                    @(posedge clk);
                    #1;
                    r = next_random();
                    triangle_m_ready = r[17];
                    @(negedge clk);
                    if (triangle_m_valid && triangle_m_ready) begin
                        compare_triangle(triangle_m_data, exp_data.pop_front());
                        compare_meta(triangle_m_metadata, exp_meta.pop_front());
                    end
                end
                @(posedge clk);
                #1;
                triangle_m_ready = 1'b1;
            end
        join
        // Last triangle has left projection once it is idle again
        do begin
            @(negedge clk);
        end while (!triangle_s_ready);
        if (triangle_m_valid) begin
            abort_run("Extra triangle at the output after the random stream");
        end
        compare_count(culled_count, expected_culled);
        @(posedge clk);
        #1;
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout, run did not finish within %0d cycles",
                                TIMEOUT_CYCLES));
        end
    end

    initial begin
        rstn                = 1'b0;
        triangle_s_valid    = 1'b0;
        triangle_s_data     = '0;
        triangle_s_metadata = '0;
        triangle_m_ready    = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;

        test_reset_state();
        test_front_facing();
        test_back_facing();
        test_depth_clamp();
        test_random_stream();

        $display("sim passed");
        $finish;
    end

endmodule
